// ==== run.sh ====
#!/bin/sh
# Build and run the time base simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --top-module systime_tb -f src.f -o systime_sim

# The log decides the result, a fatal stop never prints the pass line
./obj_dir/systime_sim | tee sim.log
grep -q "No errors" sim.log

// ==== source/daq_notify_fsm.sv ====
module daq_notify_fsm (
	input logic clk,
	input logic arst_n,
	input logic pending,
	input logic daq_grant,
	output logic load,
	output logic send_upper,
	output logic send_lower,
	output logic daq_req
);
	import systime_pkg::*;

	notify_state_t state;
	notify_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
		IDLE: begin
			if (pending)
				state_next = WAIT_GRANT;
		end
		WAIT_GRANT: begin
			if (daq_grant)
				state_next = SEND_LOWER;
		end
		SEND_LOWER: state_next = IDLE;	// Lower word always follows the upper one
		default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	// Moving the slot to the send latch frees it for the next event
	assign load = state == IDLE && pending;

	// Request stays up for as long as the collector keeps us waiting
	assign daq_req = state == WAIT_GRANT;

	assign send_upper = state == WAIT_GRANT && daq_grant;
	assign send_lower = state == SEND_LOWER;

endmodule

// ==== source/daq_word_builder.sv ====
`include "systime_cfg.svh"

module daq_word_builder (
	input logic clk,
	input logic arst_n,
	input logic set_evt,
	input logic roll_evt,
	input systime_pkg::systime_t evt_time,
	input logic load,
	input logic send_upper,
	input logic send_lower,
	output logic pending,
	output systime_pkg::daq_word_t daq_data,
	output logic daq_valid,
	output logic daq_end
);
	import systime_pkg::*;

	// Type code fills what the upper time bits leave of the first word
	localparam int TYPE_BITS = 2 * `DAQ_WORD_BITS - `DAQ_TIME_BITS;

	logic new_evt;
	time_evt_t pend_kind;
	logic [`DAQ_TIME_BITS-1:0] pend_time;
	time_evt_t send_kind;
	logic [`DAQ_TIME_BITS-1:0] send_time;
	logic [TYPE_BITS-1:0] type_code;
	daq_word_t upper_word;
	daq_word_t lower_word;

	assign new_evt = set_evt | roll_evt;

	// An event that arrives together with load stays pending
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pending <= 1'b0;
		else if (new_evt)
			pending <= 1'b1;
		else if (load)
			pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (new_evt) begin
			pend_kind <= set_evt ? SET : ROLLOVER;	// Newest event replaces the older one
			pend_time <= evt_time[`DAQ_TIME_BITS-1:0];
		end
		if (load) begin
			send_kind <= pend_kind;
			send_time <= pend_time;
		end
	end

	assign type_code = send_kind == SET ? `DAQT_SYSTIME_SET : `DAQT_SYSTIME_ROLLOVER;
	assign upper_word = {type_code, send_time[`DAQ_TIME_BITS-1:`DAQ_WORD_BITS]};
	assign lower_word = send_time[`DAQ_WORD_BITS-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
		end else begin
			daq_valid <= send_upper | send_lower;
			daq_end <= send_lower;	// Lower word closes the message
		end
	end

	always_ff @(posedge clk) begin
		if (send_upper)
			daq_data <= upper_word;
		else if (send_lower)
			daq_data <= lower_word;
	end

endmodule

// ==== source/systime_axil_regs.sv ====
`include "systime_cfg.svh"

module systime_axil_regs (
	input logic clk,
	input logic arst_n,
	input logic [`AXIL_ADDR_BITS-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input systime_pkg::daq_word_t s_wdata,
	input logic [3:0] s_wstrb,	// Registers are always written whole
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`AXIL_ADDR_BITS-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output systime_pkg::daq_word_t s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	input systime_pkg::systime_t systime,
	output systime_pkg::systime_t time_set,
	output logic time_set_en
);
	import systime_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic wr_accept_next;
	logic wr_fire;
	logic wr_to_time;
	logic rd_fire;
	logic rd_pending;
	daq_word_t set_lo;	// Staged low word of the next time set
	daq_word_t snap_hi;	// High word frozen by the last TIME_LO read

	// ========================================================================
	// Write side
	// ========================================================================

	// Address and data are accepted together in a single cycle
	assign wr_accept_next = s_awvalid & s_wvalid & ~s_awready & ~s_bvalid;
	assign wr_fire = s_awvalid & s_awready & s_wvalid & s_wready;
	assign wr_to_time = s_awaddr == `ADDR_TIME_LO || s_awaddr == `ADDR_TIME_HI;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s_awready <= 1'b0;
			s_wready <= 1'b0;
			s_bvalid <= 1'b0;
			s_bresp <= RESP_OKAY;
		end else begin
			s_awready <= wr_accept_next;
			s_wready <= wr_accept_next;
			if (wr_fire) begin
				s_bvalid <= 1'b1;
				s_bresp <= wr_to_time ? RESP_SLVERR : RESP_OKAY;	// Time is read-only
			end else if (s_bready) begin
				s_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && s_awaddr == `ADDR_SET_LO)
			set_lo <= s_wdata;
	end

	// The high word write commits the whole value, counter loads on the next edge
	assign time_set = {s_wdata, set_lo};
	assign time_set_en = wr_fire && s_awaddr == `ADDR_SET_HI;

	// ========================================================================
	// Read side
	// ========================================================================

	assign rd_fire = s_arvalid & s_arready;
	assign rd_pending = rd_fire | (s_rvalid & ~s_rready);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s_arready <= 1'b0;
			s_rvalid <= 1'b0;
		end else begin
			s_arready <= ~rd_pending;
			s_rvalid <= rd_pending;
		end
	end

	assign s_rresp = RESP_OKAY;

	// Reading the low word freezes the high word so the pair is coherent
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			case (s_araddr)
			`ADDR_TIME_LO: begin
				s_rdata <= systime[`DAQ_WORD_BITS-1:0];
				snap_hi <= systime[`SYSTIME_BITS-1:`DAQ_WORD_BITS];
			end
			`ADDR_TIME_HI: s_rdata <= snap_hi;
			`ADDR_SET_LO: s_rdata <= set_lo;
			default: s_rdata <= '0;	// SET_HI is write-only
			endcase
		end
	end

endmodule

// ==== source/systime_cfg.svh ====
`ifndef SYSTIME_CFG_SVH
`define SYSTIME_CFG_SVH

// Time base and DAQ word layout
`define SYSTIME_BITS 64
`define DAQ_WORD_BITS 32
`define DAQ_TIME_BITS 56

// Rollover fires when this many low time bits are all ones
`define ROLLOVER_BITS 28
// LEDs step when this many low time bits are all zero
`define LED_SHIFT_BITS 22

// Host register map, byte addresses
`define AXIL_ADDR_BITS 4
`define ADDR_TIME_LO 4'h0
`define ADDR_TIME_HI 4'h4
`define ADDR_SET_LO 4'h8
`define ADDR_SET_HI 4'hC

// DAQ message type codes
`define DAQT_SYSTIME_SET 8'd32
`define DAQT_SYSTIME_ROLLOVER 8'd33

`endif

// ==== source/systime_counter.sv ====
`include "systime_cfg.svh"

module systime_counter (
	input logic clk,
	input logic arst_n,
	input systime_pkg::systime_t time_set,
	input logic time_set_en,
	output systime_pkg::systime_t systime,
	output logic set_evt,
	output logic roll_evt,
	output systime_pkg::systime_t evt_time,
	output logic [7:0] leds
);
	import systime_pkg::*;

	logic led_step;
	logic roll_hit;

	assign led_step = systime[`LED_SHIFT_BITS-1:0] == '0;
	assign roll_hit = &systime[`ROLLOVER_BITS-1:0];

	// ========================================================================
	// Time base and LED chaser
	// ========================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			systime <= '0;
			leds <= 8'b00000001;
		end else begin
			if (time_set_en)
				systime <= time_set;
			else
				systime <= systime + systime_t'(1);
			if (led_step)
				leds <= {leds[6:0], leds[7]};	// Rotate left
		end
	end

	// A set wins over a rollover that falls in the same cycle
	assign set_evt = time_set_en;
	assign roll_evt = ~time_set_en & roll_hit;

	// Set events carry the written value, rollovers the current count
	assign evt_time = time_set_en ? time_set : systime;

endmodule

// ==== source/systime_pkg.sv ====
`include "systime_cfg.svh"

package systime_pkg;

	// Free-running system time
	typedef logic [`SYSTIME_BITS-1:0] systime_t;

	// One word on the DAQ outlet, also the AXI data width
	typedef logic [`DAQ_WORD_BITS-1:0] daq_word_t;

	// Which event a DAQ message reports
	typedef enum logic {
		SET,
		ROLLOVER
	} time_evt_t;

	// Notifier sequencing
	typedef enum logic [1:0] {
		IDLE,
		WAIT_GRANT,
		SEND_LOWER
	} notify_state_t;

endpackage

// ==== source/systime_top.sv ====
`include "systime_cfg.svh"

module systime_top (
	input logic clk,
	input logic arst_n,
	input logic [`AXIL_ADDR_BITS-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input systime_pkg::daq_word_t s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`AXIL_ADDR_BITS-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output systime_pkg::daq_word_t s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output logic [7:0] leds,
	output systime_pkg::daq_word_t daq_data,
	output logic daq_valid,
	output logic daq_end,
	output logic daq_req,
	input logic daq_grant
);
	import systime_pkg::*;

	systime_t systime;
	systime_t time_set;
	systime_t evt_time;
	logic time_set_en;
	logic set_evt;
	logic roll_evt;
	logic pending;
	logic load;
	logic send_upper;
	logic send_lower;

	// ========================================================================
	// Host port and time base
	// ========================================================================

	systime_axil_regs systime_axil_regs_inst (
		.clk(clk), .arst_n(arst_n),
		.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
		.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
		.systime(systime), .time_set(time_set), .time_set_en(time_set_en)
	);

	systime_counter systime_counter_inst (
		.clk(clk), .arst_n(arst_n),
		.time_set(time_set), .time_set_en(time_set_en),
		.systime(systime),
		.set_evt(set_evt), .roll_evt(roll_evt), .evt_time(evt_time),
		.leds(leds)
	);

	// ========================================================================
	// DAQ notifier
	// ========================================================================

	daq_notify_fsm daq_notify_fsm_inst (
		.clk(clk), .arst_n(arst_n),
		.pending(pending), .daq_grant(daq_grant),
		.load(load), .send_upper(send_upper), .send_lower(send_lower),
		.daq_req(daq_req)
	);

	daq_word_builder daq_word_builder_inst (
		.clk(clk), .arst_n(arst_n),
		.set_evt(set_evt), .roll_evt(roll_evt), .evt_time(evt_time),
		.load(load), .send_upper(send_upper), .send_lower(send_lower),
		.pending(pending),
		.daq_data(daq_data), .daq_valid(daq_valid), .daq_end(daq_end)
	);

endmodule

// ==== src.f ====
+incdir+source
source/systime_pkg.sv
source/systime_axil_regs.sv
source/systime_counter.sv
source/daq_notify_fsm.sv
source/daq_word_builder.sv
source/systime_top.sv
testbench/systime_properties.sv
testbench/systime_tb.sv

// ==== testbench/systime_properties.sv ====
module systime_properties (
	input logic clk,
	input logic arst_n,
	input logic s_bvalid,
	input logic s_bready,
	input logic s_rvalid,
	input logic s_rready,
	input logic daq_req,
	input logic daq_grant,
	input logic daq_valid,
	input logic daq_end
);

	// ========================================================================
	// AXI response channels
	// ========================================================================

	// A response stays up until the master takes it
	bvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		s_bvalid && !s_bready |=> s_bvalid)
		else $error("Write response withdrawn before bready");

	rvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		s_rvalid && !s_rready |=> s_rvalid)
		else $error("Read data withdrawn before rready");

	// ========================================================================
	// DAQ outlet
	// ========================================================================

	req_held: assert property (@(posedge clk) disable iff (!arst_n)
		daq_req && !daq_grant |=> daq_req)
		else $error("daq_req dropped before the grant");

	end_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
		daq_end |-> daq_valid)	// The closing word is always a valid word
		else $error("daq_end seen without daq_valid");

endmodule

// ==== testbench/systime_tb.sv ====
`include "systime_cfg.svh"

module systime_tb;
	import systime_pkg::*;

	logic clk;
	logic arst_n;
	logic [`AXIL_ADDR_BITS-1:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	daq_word_t s_wdata;
	logic [3:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [`AXIL_ADDR_BITS-1:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	daq_word_t s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	logic [7:0] leds;
	daq_word_t daq_data;
	logic daq_valid;
	logic daq_end;
	logic daq_req;
	logic daq_grant;

	logic [31:0] lfsr = 32'd88441;
	longint cycles = 0;
	systime_t base_val;	// Model time equals base_val at base_cycle, then counts up
	longint base_cycle;
	daq_word_t staged_lo;
	logic [7:0] exp_leds;
	daq_word_t exp_words[$];

	systime_top systime_top_inst (.*);

	bind systime_top systime_properties systime_properties_inst (
		.clk(clk), .arst_n(arst_n),
		.s_bvalid(s_bvalid), .s_bready(s_bready), .s_rvalid(s_rvalid), .s_rready(s_rready),
		.daq_req(daq_req), .daq_grant(daq_grant), .daq_valid(daq_valid), .daq_end(daq_end)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	// ========================================================================
	// Random source, model and checks
	// ========================================================================

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < count; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;	// Galois step
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic systime_t model_time();
		return base_val + 64'(cycles - base_cycle);
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual)
			stop_with_error($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	// Upper word is the type code over stamp bits 55:32, lower word the low stamp bits
	task automatic expect_message(input logic [7:0] code, input systime_t stamp);
		exp_words.push_back({code, stamp[`DAQ_TIME_BITS-1:`DAQ_WORD_BITS]});
		exp_words.push_back(stamp[`DAQ_WORD_BITS-1:0]);
	endtask

	// ========================================================================
	// Bus and DAQ tasks, all start and end on a falling edge
	// ========================================================================

	task automatic axil_write(input logic [3:0] addr, input daq_word_t data, output logic [1:0] resp);
		int n;
		int stall;
		s_awaddr = addr;
		s_wdata = data;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		n = 0;
		while (!(s_awready && s_wready)) begin
			@(negedge clk);
			n++;
			if (n > 16)
				stop_with_error("Timed out waiting for the write to be accepted");
		end
		if (addr == `ADDR_SET_LO)
			staged_lo = data;
		if (addr == `ADDR_SET_HI) begin
			base_val = {data, staged_lo};
			base_cycle = cycles + 1;	// Counter holds the new value after the next edge
		end
		stall = random_bits(3);
		@(negedge clk);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		repeat (stall) @(negedge clk);
		s_bready = 1'b1;
		n = 0;
		while (!s_bvalid) begin
			@(negedge clk);
			n++;
			if (n > 16)
				stop_with_error("Timed out waiting for the write response");
		end
		resp = s_bresp;
		@(negedge clk);
		s_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output daq_word_t data, output systime_t at_fire);
		int n;
		int stall;
		s_araddr = addr;
		s_arvalid = 1'b1;
		n = 0;
		while (!s_arready) begin
			@(negedge clk);
			n++;
			if (n > 16)
				stop_with_error("Timed out waiting for the read address to be accepted");
		end
		at_fire = model_time();	// Read data is the time seen at the accepting edge
		stall = random_bits(3);
		@(negedge clk);
		s_arvalid = 1'b0;
		repeat (stall) @(negedge clk);
		s_rready = 1'b1;
		n = 0;
		while (!s_rvalid) begin
			@(negedge clk);
			n++;
			if (n > 16)
				stop_with_error("Timed out waiting for read data");
		end
		data = s_rdata;
		check("read response", 64'(2'b00), 64'(s_rresp));
		@(negedge clk);
		s_rready = 1'b0;
	endtask

	task automatic read_time(input string name);
		daq_word_t lo;
		daq_word_t hi;
		systime_t expected;
		systime_t ignored;
		axil_read(`ADDR_TIME_LO, lo, expected);
		axil_read(`ADDR_TIME_HI, hi, ignored);
		check({name, " low word"}, 64'(expected[31:0]), 64'(lo));
		check({name, " high word"}, 64'(expected[63:32]), 64'(hi));
	endtask

	task automatic set_time(input systime_t value);
		logic [1:0] resp;
		axil_write(`ADDR_SET_LO, value[31:0], resp);
		check("SET_LO response", 64'(2'b00), 64'(resp));
		axil_write(`ADDR_SET_HI, value[63:32], resp);
		check("SET_HI response", 64'(2'b00), 64'(resp));
		expect_message(`DAQT_SYSTIME_SET, value);
	endtask

	task automatic receive_message(input string name);
		int n;
		int delay;
		daq_word_t upper;
		daq_word_t lower;
		n = 0;
		while (!daq_req) begin
			@(negedge clk);
			n++;
			if (n > 64)
				stop_with_error({"Timed out waiting for daq_req before ", name});
		end
		delay = random_bits(3);
		repeat (delay) begin
			check({name, " valid before grant"}, 64'(1'b0), 64'(daq_valid));
			@(negedge clk);
		end
		daq_grant = 1'b1;
		@(negedge clk);
		daq_grant = 1'b0;
		upper = exp_words.pop_front();
		lower = exp_words.pop_front();
		check({name, " upper flags"}, 64'(3'b010), 64'({daq_req, daq_valid, daq_end}));
		check({name, " upper word"}, 64'(upper), 64'(daq_data));
		@(negedge clk);
		check({name, " lower flags"}, 64'(3'b011), 64'({daq_req, daq_valid, daq_end}));
		check({name, " lower word"}, 64'(lower), 64'(daq_data));
		@(negedge clk);
		check({name, " valid after end"}, 64'(1'b0), 64'(daq_valid));
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin : main
		systime_t value;
		logic [1:0] resp;
		int n;
		daq_word_t lo_word;
		daq_word_t hi_word;
		systime_t snap_time;
		systime_t ignored;
		arst_n = 1'b0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = 4'hF;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		daq_grant = 1'b0;
		staged_lo = '0;
		repeat (16) @(negedge clk);
		check("reset outputs", 64'(16'h0001), 64'({daq_req, daq_valid, daq_end, s_bvalid,
			s_rvalid, s_awready, s_wready, s_arready, leds}));
		arst_n = 1'b1;
		base_val = '0;
		base_cycle = cycles;
		exp_leds = 8'b00000010;	// Time zero steps the chaser on the first edge
		repeat (4) @(negedge clk);
		check("leds after reset", 64'(exp_leds), 64'(leds));
		read_time("time after reset");

		// Low bits kept clear of any LED step or rollover during the test
		repeat (5) begin
			value = {random_bits(32), (random_bits(32) & 32'h77DF_FFFF) | 32'h0000_0100};
			set_time(value);
			receive_message("set message");
			read_time("time after set");
			check("leds after set", 64'(exp_leds), 64'(leds));
			repeat (32) @(negedge clk);
		end

		// TIME_HI returns the high word as it was at the TIME_LO read
		axil_read(`ADDR_TIME_LO, lo_word, snap_time);
		value = {~snap_time[63:32], (random_bits(32) & 32'h77DF_FFFF) | 32'h0000_0100};
		set_time(value);
		receive_message("set between reads");
		axil_read(`ADDR_TIME_HI, hi_word, ignored);
		check("snapshot low word", 64'(snap_time[31:0]), 64'(lo_word));
		check("snapshot high word", 64'(snap_time[63:32]), 64'(hi_word));
		read_time("time after snapshot");
		repeat (32) @(negedge clk);

		value = {random_bits(32), random_bits(32) | 32'h0FFF_FFFF};
		set_time(value - 64'd16);
		expect_message(`DAQT_SYSTIME_ROLLOVER, value);
		receive_message("set before rollover");
		receive_message("rollover message");
		exp_leds = {exp_leds[6:0], exp_leds[7]};	// Count after the rollover is a step too
		read_time("time after rollover");
		check("leds after rollover", 64'(exp_leds), 64'(leds));
		repeat (32) @(negedge clk);

		value = {random_bits(32), (random_bits(32) & 32'hFFC0_0000) | 32'h0040_0000};
		set_time(value - 64'd5);
		receive_message("set before led step");
		exp_leds = {exp_leds[6:0], exp_leds[7]};
		n = 0;
		while (leds !== exp_leds) begin
			@(negedge clk);
			n++;
			if (n > 64)
				stop_with_error("Timed out waiting for the LEDs to rotate");
		end
		repeat (32) @(negedge clk);

		axil_write(`ADDR_TIME_LO, random_bits(32), resp);
		check("TIME_LO write response", 64'(2'b10), 64'(resp));
		axil_write(`ADDR_TIME_HI, random_bits(32), resp);
		check("TIME_HI write response", 64'(2'b10), 64'(resp));
		read_time("time after refused write");
		check("daq_req after refused write", 64'(1'b0), 64'(daq_req));

		$display("No errors");
		$finish;
	end

endmodule
